// File: ucore_top.f
+incdir+rtl
rtl/ucore_isa_pkg.sv
rtl/ucore_bus_pkg.sv
rtl/ucore_regfile.sv
rtl/ucore_alu.sv
rtl/ucore_fetch.sv
rtl/ucore_issue.sv
rtl/ucore_lsu.sv
rtl/ucore_top.sv
testbench/ucore_tb.sv

// File: Makefile
# Verilator build and run of the ucore testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module ucore_tb -f ucore_top.f --Mdir obj_dir -o ucore_sim
	./obj_dir/ucore_sim | tee $(LOG)
	@grep -qx ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/ucore_tb.sv
// Directed testbench for ucore_top with instruction and data memory models
// Programs are built from instruction encoders, results are read at data-bus stores

`timescale 1ns/10ps
`default_nettype none

module ucore_tb;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0100;
  localparam int          MEM_WORDS = 256;
  localparam int          TIMEOUT   = 4000;

  // Operation codes as {funct7[5], funct3}
  localparam logic [3:0] K_ADD  = 4'b0000;
  localparam logic [3:0] K_SLL  = 4'b0001;
  localparam logic [3:0] K_SLT  = 4'b0010;
  localparam logic [3:0] K_SLTU = 4'b0011;
  localparam logic [3:0] K_XOR  = 4'b0100;
  localparam logic [3:0] K_SRL  = 4'b0101;
  localparam logic [3:0] K_OR   = 4'b0110;
  localparam logic [3:0] K_AND  = 4'b0111;
  localparam logic [3:0] K_SUB  = 4'b1000;
  localparam logic [3:0] K_SRA  = 4'b1101;

  logic        clk          = 1'b0;
  logic        rst_ni       = 1'b0;
  logic [31:0] boot_addr    = BOOT_ADDR;
  logic        instr_gnt    = 1'b0;
  logic        instr_rvalid = 1'b0;
  logic [31:0] instr_rdata  = 32'h0;
  logic        data_gnt     = 1'b0;
  logic        data_rvalid  = 1'b0;
  logic [31:0] data_rdata   = 32'h0;
  logic        instr_req;
  logic [31:0] instr_addr;
  logic        data_req;
  logic        data_we;
  logic [3:0]  data_be;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;

  integer      seed     = 65039;
  logic        bp_en    = 1'b0;
  int          n_checks = 0;
  int          n_errors = 0;
  int          slot;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  logic [31:0] prog [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] fetch_q [$];
  logic [31:0] st_addr [$];
  logic [31:0] st_data [$];
  logic [3:0]  st_be [$];

  // Bus model state
  logic        i_pend;
  logic        d_pend;
  int          i_wait;
  int          d_wait;
  logic [31:0] i_addr;
  logic [31:0] d_addr;

  ucore_top u_ucore_top (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr),
    .instr_req_o    (instr_req),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_addr_o   (instr_addr),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_gnt_i     (data_gnt),
    .data_rvalid_i  (data_rvalid),
    .data_we_o      (data_we),
    .data_be_o      (data_be),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_rdata_i   (data_rdata)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Encoders and reference
  ////////////////////
  function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] enc_r(input logic [3:0] kind, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    return {1'b0, kind[3], 5'b0, rs2, rs1, kind[2:0], rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  // ADDI x0, x0, index
  function automatic logic [31:0] nop_word(input logic [7:0] idx);
    return enc_i(3'b000, 5'd0, 5'd0, {4'b0, idx});
  endfunction

  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return {16'hD00D, 6'b0, idx, 2'b00};
  endfunction

  function automatic logic [31:0] expect_alu(input logic [3:0] kind, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (kind)
      K_ADD:   return a + b;
      K_SUB:   return a - b;
      K_SLL:   return a << sh;
      K_SRL:   return a >> sh;
      // Vacated high bits take the sign
      K_SRA:   return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);
      K_SLT:   return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
      K_SLTU:  return {31'b0, a < b};
      K_XOR:   return a ^ b;
      K_OR:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic int pick_delay();
    if (bp_en) begin
      return {$random(seed)} % 4;
    end
    return 0;
  endfunction

  ////////////////////
  // Bus memory models
  ////////////////////
  always @(posedge clk) begin
    if (!rst_ni) begin
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
      data_gnt     <= 1'b0;
      data_rvalid  <= 1'b0;
      i_pend = 1'b0;
      d_pend = 1'b0;
      i_wait = 0;
      d_wait = 0;
      fetch_q.delete();
      st_addr.delete();
      st_data.delete();
      st_be.delete();
      for (int i = 0; i < MEM_WORDS; i++) begin
        dmem[i] = fill_word(i[7:0]);
      end
    end else begin
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
      data_gnt     <= 1'b0;
      data_rvalid  <= 1'b0;
      // Instruction bus
      if (i_pend) begin
        if (i_wait == 0) begin
          instr_rvalid <= 1'b1;
          instr_rdata  <= imem[i_addr[9:2]];
          i_pend = 1'b0;
          i_wait = pick_delay();
        end else begin
          i_wait--;
        end
      end else if (instr_req) begin
        if (i_wait == 0) begin
          instr_gnt <= 1'b1;
          i_addr = instr_addr;
          fetch_q.push_back(instr_addr);
          i_pend = 1'b1;
          i_wait = pick_delay();
        end else begin
          i_wait--;
        end
      end
      // Data bus with stores landing in memory at grant
      if (d_pend) begin
        if (d_wait == 0) begin
          data_rvalid <= 1'b1;
          data_rdata  <= dmem[d_addr[9:2]];
          d_pend = 1'b0;
          d_wait = pick_delay();
        end else begin
          d_wait--;
        end
      end else if (data_req) begin
        if (d_wait == 0) begin
          data_gnt <= 1'b1;
          d_addr = data_addr;
          if (data_we) begin
            dmem[data_addr[9:2]] = data_wdata;
            st_addr.push_back(data_addr);
            st_data.push_back(data_wdata);
            st_be.push_back(data_be);
          end
          d_pend = 1'b1;
          d_wait = pick_delay();
        end else begin
          d_wait--;
        end
      end
    end
  end

  ////////////////////
  // Program building
  ////////////////////
  task automatic check_eq(input string what, input logic [31:0] expected,
                          input logic [31:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", what, expected, actual);
    end
  endtask

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    slot = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // LUI plus ADDI with the upper part rounded for the signed low half
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = (value + 32'h800) >> 12;
    emit(enc_lui(rd, upper[19:0]));
    emit(enc_i(3'b000, rd, rd, value[11:0]));
  endtask

  task automatic store_expect(input logic [4:0] rs, input logic [31:0] value);
    logic [11:0] off;
    off = 12'(slot * 4);
    emit(enc_sw(rs, 5'd0, off));
    exp_addr.push_back({20'b0, off});
    exp_data.push_back(value);
    slot++;
  endtask

  task automatic imm_case(input logic [3:0] kind, input logic [4:0] rs1,
                          input logic [31:0] a, input logic [11:0] imm);
    logic [11:0] field;
    logic [31:0] b;
    if (kind[2:0] == 3'b001 || kind[2:0] == 3'b101) begin
      field = {1'b0, kind[3], 5'b0, imm[4:0]};
      b     = {27'b0, imm[4:0]};
    end else begin
      field = imm;
      b     = {{20{imm[11]}}, imm};
    end
    emit(enc_i(kind[2:0], 5'd3, rs1, field));
    store_expect(5'd3, expect_alu(kind, a, b));
  endtask

  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = nop_word(i[7:0]);
    end
    foreach (prog[i]) begin
      imem[BOOT_ADDR[9:2] + i[7:0]] = prog[i];
    end
  endtask

  // Reset, load, run until all expected stores are seen, then compare
  task automatic run_program(input string name, input logic bp);
    int cycles;
    @(posedge clk);
    rst_ni <= 1'b0;
    bp_en  <= bp;
    @(negedge clk);
    load_program();
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_eq({name, " instr_req in reset"}, 32'd0, {31'b0, instr_req});
    check_eq({name, " data_req in reset"}, 32'd0, {31'b0, data_req});
    check_eq({name, " data_we in reset"}, 32'd0, {31'b0, data_we});
    @(posedge clk);
    rst_ni <= 1'b1;
    cycles = 0;
    while (st_data.size() < exp_data.size() && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (st_data.size() < exp_data.size()) begin
      n_errors++;
      $display("%s timed out with %0d of %0d stores seen", name, st_data.size(),
               exp_data.size());
    end
    for (int i = 0; i < exp_data.size() && i < st_data.size(); i++) begin
      check_eq({name, " store addr"}, exp_addr[i], st_addr[i]);
      check_eq({name, " store data"}, exp_data[i], st_data[i]);
      check_eq({name, " store be"}, 32'hF, {28'b0, st_be[i]});
    end
    if (fetch_q.size() < prog.size()) begin
      n_errors++;
      $display("%s fetched only %0d of %0d program words", name, fetch_q.size(), prog.size());
    end else begin
      for (int i = 0; i < prog.size(); i++) begin
        check_eq({name, " fetch addr"}, BOOT_ADDR + 4 * i, fetch_q[i]);
      end
    end
  endtask

  ////////////////////
  // Directed tests
  ////////////////////
  task automatic test_reset_fetch();
    new_program();
    load_const(5'd7, 32'h1234_5678);
    store_expect(5'd7, 32'h1234_5678);
    run_program("reset_fetch", 1'b0);
  endtask

  task automatic test_alu_ops();
    logic [3:0]  kinds [10];
    logic [31:0] ra;
    logic [31:0] rb;
    kinds = '{K_ADD, K_SUB, K_SLL, K_SLT, K_SLTU, K_XOR, K_SRL, K_SRA, K_OR, K_AND};
    new_program();
    // x1 = -1234, x2 negative with a large magnitude
    load_const(5'd1, 32'hFFFF_FB2E);
    load_const(5'd2, 32'h8000_0F10);
    imm_case(K_ADD, 5'd1, 32'hFFFF_FB2E, 12'hFB3);
    imm_case(K_SLT, 5'd1, 32'hFFFF_FB2E, 12'hFFB);
    imm_case(K_SLTU, 5'd1, 32'hFFFF_FB2E, 12'hFFB);
    imm_case(K_SLT, 5'd2, 32'h8000_0F10, 12'h005);
    imm_case(K_SLTU, 5'd2, 32'h8000_0F10, 12'h005);
    imm_case(K_XOR, 5'd1, 32'hFFFF_FB2E, 12'h8F0);
    imm_case(K_OR, 5'd2, 32'h8000_0F10, 12'hA05);
    imm_case(K_AND, 5'd1, 32'hFFFF_FB2E, 12'hF0F);
    imm_case(K_SLL, 5'd1, 32'hFFFF_FB2E, 12'h007);
    imm_case(K_SRL, 5'd2, 32'h8000_0F10, 12'h004);
    imm_case(K_SRA, 5'd2, 32'h8000_0F10, 12'h004);
    imm_case(K_SRA, 5'd1, 32'hFFFF_FB2E, 12'h01F);
    emit(enc_lui(5'd3, 20'hABCDE));
    store_expect(5'd3, 32'hABCD_E000);
    // Register-register group on random operands
    ra = $random(seed) | 32'h8000_0000;
    rb = $random(seed);
    load_const(5'd5, ra);
    load_const(5'd6, rb);
    foreach (kinds[i]) begin
      emit(enc_r(kinds[i], 5'd3, 5'd5, 5'd6));
      store_expect(5'd3, expect_alu(kinds[i], ra, rb));
    end
    run_program("alu_ops", 1'b0);
  endtask

  // Same program and expectations as alu_ops
  task automatic test_backpressure();
    run_program("backpressure", 1'b1);
  endtask

  task automatic test_load_store();
    new_program();
    load_const(5'd1, 32'h5EED_C0DE);
    store_expect(5'd1, 32'h5EED_C0DE);
    emit(enc_lw(5'd2, 5'd0, 12'h000));
    emit(enc_i(3'b000, 5'd3, 5'd2, 12'h005));
    store_expect(5'd2, 32'h5EED_C0DE);
    store_expect(5'd3, 32'h5EED_C0E3);
    // Untouched word still holds its fill value
    emit(enc_lw(5'd4, 5'd0, 12'h100));
    store_expect(5'd4, fill_word(8'd64));
    run_program("load_store", 1'b0);
  endtask

  task automatic test_x0_writes();
    new_program();
    load_const(5'd1, 32'h0000_0042);
    emit(enc_i(3'b000, 5'd0, 5'd1, 12'h123));
    emit(enc_lui(5'd0, 20'h12345));
    emit(enc_r(K_ADD, 5'd0, 5'd1, 5'd1));
    emit(enc_lw(5'd0, 5'd0, 12'h100));
    store_expect(5'd0, 32'h0);
    emit(enc_r(K_ADD, 5'd3, 5'd0, 5'd1));
    store_expect(5'd3, 32'h0000_0042);
    run_program("x0_writes", 1'b0);
  endtask

  initial begin
    test_reset_fetch();
    test_alu_ops();
    test_backpressure();
    test_load_store();
    test_x0_writes();
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/ucore_top.sv
// Top level of the ucore RV32I subset core
// Instruction and data buses use req/gnt/rvalid with one access outstanding

`timescale 1ns/10ps
`default_nettype none

`include "ucore_cfg.svh"

module ucore_top import ucore_bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic [`UCORE_XLEN-1:0] boot_addr_i,
  // Instruction bus
  output logic                   instr_req_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  output logic [`UCORE_XLEN-1:0] instr_addr_o,
  input  logic [`UCORE_XLEN-1:0] instr_rdata_i,
  // Data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic                   data_we_o,
  output logic [`UCORE_BE_W-1:0] data_be_o,
  output logic [`UCORE_XLEN-1:0] data_addr_o,
  output logic [`UCORE_XLEN-1:0] data_wdata_o,
  input  logic [`UCORE_XLEN-1:0] data_rdata_i
);

  fetch_rsp_t             fetch;
  mem_req_t               mem;
  logic                   retire;
  logic                   mem_done;
  logic [`UCORE_XLEN-1:0] mem_rdata;

  ////////////////////
  // Fetch
  ////////////////////
  ucore_fetch u_fetch (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .boot_addr_i    (boot_addr_i),
    .retire_i       (retire),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .fetch_o        (fetch)
  );

  ////////////////////
  // Issue and execute
  ////////////////////
  ucore_issue u_issue (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .fetch_i     (fetch),
    .mem_done_i  (mem_done),
    .mem_rdata_i (mem_rdata),
    .mem_o       (mem),
    .retire_o    (retire)
  );

  ////////////////////
  // Load/store
  ////////////////////
  ucore_lsu u_lsu (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .mem_i         (mem),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_be_o     (data_be_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i),
    .mem_done_o    (mem_done),
    .mem_rdata_o   (mem_rdata)
  );

endmodule

`default_nettype wire

// File: rtl/ucore_lsu.sv
// Load/store unit: one word access at a time on the data bus
// Pulses mem_done_o with the load data when the response arrives

`timescale 1ns/10ps
`default_nettype none

`include "ucore_cfg.svh"

module ucore_lsu import ucore_bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  mem_req_t               mem_i,
  // Data bus
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  output logic                   data_we_o,
  output logic [`UCORE_BE_W-1:0] data_be_o,
  output logic [`UCORE_XLEN-1:0] data_addr_o,
  output logic [`UCORE_XLEN-1:0] data_wdata_o,
  input  logic [`UCORE_XLEN-1:0] data_rdata_i,
  // Completion towards issue
  output logic                   mem_done_o,
  output logic [`UCORE_XLEN-1:0] mem_rdata_o
);

  typedef enum logic [1:0] {IDLE, REQ, WAIT_RVALID, DONE_WAIT} lsu_state_e;

  lsu_state_e             state_q;
  logic                   we_q;
  logic [`UCORE_XLEN-1:0] addr_q;
  logic [`UCORE_XLEN-1:0] wdata_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      we_q    <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (mem_i.valid) begin
            we_q    <= mem_i.we;
            state_q <= REQ;
          end
        end
        REQ:         if (data_gnt_i) state_q <= WAIT_RVALID;
        WAIT_RVALID: if (data_rvalid_i) state_q <= DONE_WAIT;
        // Hold off until issue has dropped this access
        DONE_WAIT:   if (!mem_i.valid) state_q <= IDLE;
        default:     state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && mem_i.valid) begin
      addr_q  <= mem_i.addr;
      wdata_q <= mem_i.wdata;
    end
  end

  assign data_req_o   = (state_q == REQ);
  assign data_we_o    = we_q;
  assign data_be_o    = {`UCORE_BE_W{1'b1}};
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;

  assign mem_done_o  = (state_q == WAIT_RVALID) & data_rvalid_i;
  assign mem_rdata_o = data_rdata_i;

endmodule

`default_nettype wire

// File: rtl/ucore_issue.sv
// Decode, operand select and writeback for the held instruction
// Retires ALU ops at once and memory ops when the load/store unit is done

`timescale 1ns/10ps
`default_nettype none

`include "ucore_cfg.svh"

module ucore_issue import ucore_isa_pkg::*, ucore_bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  fetch_rsp_t             fetch_i,
  input  logic                   mem_done_i,
  input  logic [`UCORE_XLEN-1:0] mem_rdata_i,
  output mem_req_t               mem_o,
  output logic                   retire_o
);

  decoded_t               dec;
  logic [2:0]             funct3;
  logic                   funct7_ok;
  logic [`UCORE_XLEN-1:0] rs1_rdata;
  logic [`UCORE_XLEN-1:0] rs2_rdata;
  logic [`UCORE_XLEN-1:0] alu_operand_b;
  logic [`UCORE_XLEN-1:0] alu_result;
  logic [`UCORE_XLEN-1:0] rf_wdata;
  logic                   rf_we;

  assign funct3    = fetch_i.instr[14:12];
  // Only 0000000 and 0100000 are legal in the register-register group
  assign funct7_ok = ~fetch_i.instr[31] & (fetch_i.instr[29:25] == 5'b0);

  ////////////////////
  // Decoder
  ////////////////////
  always_comb begin
    dec         = '0;
    dec.alu_op  = ADD;
    dec.rs1     = fetch_i.instr[19:15];
    dec.rs2     = fetch_i.instr[24:20];
    dec.rd      = fetch_i.instr[11:7];
    dec.imm     = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
    case (fetch_i.instr[6:0])
      OP_IMM: begin
        dec.use_imm = 1'b1;
        dec.reg_we  = 1'b1;
        case (funct3)
          3'b000:  dec.alu_op = ADD;
          3'b001:  dec.alu_op = SLL;
          3'b010:  dec.alu_op = SLT;
          3'b011:  dec.alu_op = SLTU;
          3'b100:  dec.alu_op = XOR;
          3'b101:  dec.alu_op = fetch_i.instr[30] ? SRA : SRL;
          3'b110:  dec.alu_op = OR;
          default: dec.alu_op = AND;
        endcase
      end
      OP: begin
        dec.reg_we = funct7_ok;
        case ({fetch_i.instr[30], funct3})
          4'b0000: dec.alu_op = ADD;
          4'b1000: dec.alu_op = SUB;
          4'b0001: dec.alu_op = SLL;
          4'b0010: dec.alu_op = SLT;
          4'b0011: dec.alu_op = SLTU;
          4'b0100: dec.alu_op = XOR;
          4'b0101: dec.alu_op = SRL;
          4'b1101: dec.alu_op = SRA;
          4'b0110: dec.alu_op = OR;
          4'b0111: dec.alu_op = AND;
          default: dec.reg_we = 1'b0;
        endcase
      end
      LUI: begin
        dec.imm    = {fetch_i.instr[31:12], 12'b0};
        dec.is_lui = 1'b1;
        dec.reg_we = 1'b1;
      end
      LOAD: begin
        // Word loads only
        dec.use_imm = 1'b1;
        dec.mem     = (funct3 == 3'b010);
        dec.reg_we  = (funct3 == 3'b010);
      end
      STORE: begin
        dec.imm     = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:25], fetch_i.instr[11:7]};
        dec.use_imm = 1'b1;
        dec.mem     = (funct3 == 3'b010);
        dec.mem_we  = (funct3 == 3'b010);
      end
      default: ;
    endcase
  end

  ucore_regfile u_regfile (
    .clk       (clk),
    .rst_ni    (rst_ni),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .waddr_i   (dec.rd),
    .we_i      (rf_we),
    .wdata_i   (rf_wdata),
    .rdata_a_o (rs1_rdata),
    .rdata_b_o (rs2_rdata)
  );

  assign alu_operand_b = dec.use_imm ? dec.imm : rs2_rdata;

  // Also forms rs1 + imm for loads and stores
  ucore_alu u_alu (
    .op_i        (dec.alu_op),
    .operand_a_i (rs1_rdata),
    .operand_b_i (alu_operand_b),
    .result_o    (alu_result)
  );

  ////////////////////
  // Retire and writeback
  ////////////////////
  assign mem_o = '{valid: fetch_i.valid & dec.mem, we: dec.mem_we,
                   addr: alu_result, wdata: rs2_rdata};

  assign retire_o = fetch_i.valid & (dec.mem ? mem_done_i : 1'b1);
  assign rf_we    = retire_o & dec.reg_we;
  assign rf_wdata = dec.mem ? mem_rdata_i : (dec.is_lui ? dec.imm : alu_result);

endmodule

`default_nettype wire

// File: rtl/ucore_fetch.sv
// Instruction fetch unit: keeps the PC, runs the instruction bus and
// holds the fetched word until issue retires it

`timescale 1ns/10ps
`default_nettype none

`include "ucore_cfg.svh"

module ucore_fetch import ucore_bus_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_ni,
  input  logic [`UCORE_XLEN-1:0] boot_addr_i,
  input  logic                   retire_i,
  // Instruction bus
  output logic                   instr_req_o,
  output logic [`UCORE_XLEN-1:0] instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [`UCORE_XLEN-1:0] instr_rdata_i,
  // Held word towards issue
  output fetch_rsp_t             fetch_o
);

  typedef enum logic [1:0] {REQ, WAIT_RVALID, HOLD} fetch_state_e;

  fetch_state_e           state_q;
  logic                   req_q;
  logic [`UCORE_XLEN-1:0] pc_q;
  logic [`UCORE_XLEN-1:0] instr_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= REQ;
      req_q   <= 1'b0;
      pc_q    <= '0;
    end else begin
      case (state_q)
        REQ: begin
          if (!req_q) begin
            // Only reached right after reset
            req_q <= 1'b1;
            pc_q  <= boot_addr_i;
          end else if (instr_gnt_i) begin
            req_q   <= 1'b0;
            state_q <= WAIT_RVALID;
          end
        end
        WAIT_RVALID: begin
          if (instr_rvalid_i) begin
            state_q <= HOLD;
          end
        end
        HOLD: begin
          // Next word is always the following one
          if (retire_i) begin
            req_q   <= 1'b1;
            pc_q    <= pc_q + `UCORE_XLEN'(4);
            state_q <= REQ;
          end
        end
        default: state_q <= REQ;
      endcase
    end
  end

  // Instruction word capture
  always_ff @(posedge clk) begin
    if (state_q == WAIT_RVALID && instr_rvalid_i) begin
      instr_q <= instr_rdata_i;
    end
  end

  assign instr_req_o  = req_q;
  assign instr_addr_o = pc_q;

  assign fetch_o = '{valid: (state_q == HOLD), pc: pc_q, instr: instr_q};

endmodule

`default_nettype wire

// File: rtl/ucore_alu.sv
// Integer ALU: add/sub, shifts, set-less-than and bitwise logic
// Purely combinational, one result per operation code

`timescale 1ns/10ps
`default_nettype none

`include "ucore_cfg.svh"

module ucore_alu import ucore_isa_pkg::*; (
  input  alu_op_e                op_i,
  input  logic [`UCORE_XLEN-1:0] operand_a_i,
  input  logic [`UCORE_XLEN-1:0] operand_b_i,
  output logic [`UCORE_XLEN-1:0] result_o
);

  logic                   is_sub;
  logic [`UCORE_XLEN-1:0] adder_b;
  logic [`UCORE_XLEN-1:0] sum;
  logic [4:0]             shamt;
  logic                   lt_signed;
  logic                   lt_unsigned;

  // Shared adder that subtracts as a + ~b + 1
  assign is_sub  = (op_i == SUB);
  assign adder_b = is_sub ? ~operand_b_i : operand_b_i;
  assign sum     = operand_a_i + adder_b + {{(`UCORE_XLEN-1){1'b0}}, is_sub};

  assign shamt = operand_b_i[4:0];

  // Comparators
  assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
  assign lt_unsigned = operand_a_i < operand_b_i;

  always_comb begin
    case (op_i)
      ADD,
      SUB:     result_o = sum;
      SLL:     result_o = operand_a_i << shamt;
      SRL:     result_o = operand_a_i >> shamt;
      SRA:     result_o = $unsigned($signed(operand_a_i) >>> shamt);
      SLT:     result_o = {{(`UCORE_XLEN-1){1'b0}}, lt_signed};
      SLTU:    result_o = {{(`UCORE_XLEN-1){1'b0}}, lt_unsigned};
      XOR:     result_o = operand_a_i ^ operand_b_i;
      OR:      result_o = operand_a_i | operand_b_i;
      AND:     result_o = operand_a_i & operand_b_i;
      default: result_o = sum;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/ucore_regfile.sv
// Integer register file, two asynchronous read ports and one write port
// x0 reads as zero and ignores writes

`timescale 1ns/10ps
`default_nettype none

`include "ucore_cfg.svh"

module ucore_regfile (
  input  logic                     clk,
  input  logic                     rst_ni,
  input  logic [`UCORE_REG_AW-1:0] raddr_a_i,
  input  logic [`UCORE_REG_AW-1:0] raddr_b_i,
  input  logic [`UCORE_REG_AW-1:0] waddr_i,
  input  logic                     we_i,
  input  logic [`UCORE_XLEN-1:0]   wdata_i,
  output logic [`UCORE_XLEN-1:0]   rdata_a_o,
  output logic [`UCORE_XLEN-1:0]   rdata_b_o
);

  logic [`UCORE_XLEN-1:0] regs_q [`UCORE_NREGS];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `UCORE_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Hardwired zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: rtl/ucore_bus_pkg.sv
// Bus-side types passed between fetch, issue and the load/store unit
// Import with ucore_bus_pkg::* in the module header

`default_nettype none

`include "ucore_cfg.svh"

package ucore_bus_pkg;

  // Instruction word held by the fetch unit until it retires
  typedef struct packed {
    logic                 valid;
    logic [`UCORE_XLEN-1:0] pc;
    logic [`UCORE_XLEN-1:0] instr;
  } fetch_rsp_t;

  // One word access towards the data bus
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [`UCORE_XLEN-1:0] addr;
    logic [`UCORE_XLEN-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// File: rtl/ucore_isa_pkg.sv
// Instruction-set types shared by the decoder in ucore_issue and the ALU
// Import with ucore_isa_pkg::* in the module header

`default_nettype none

`include "ucore_cfg.svh"

package ucore_isa_pkg;

  // Major opcode field, instr[6:0]
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // Encoded as {funct7[5], funct3} of the register-register group
  typedef enum logic [3:0] {
    ADD  = 4'b0000,
    SLL  = 4'b0001,
    SLT  = 4'b0010,
    SLTU = 4'b0011,
    XOR  = 4'b0100,
    SRL  = 4'b0101,
    OR   = 4'b0110,
    AND  = 4'b0111,
    SUB  = 4'b1000,
    SRA  = 4'b1101
  } alu_op_e;

  // Decoded form of one held instruction
  typedef struct packed {
    alu_op_e                alu_op;
    logic [`UCORE_REG_AW-1:0] rs1;
    logic [`UCORE_REG_AW-1:0] rs2;
    logic [`UCORE_REG_AW-1:0] rd;
    logic [`UCORE_XLEN-1:0]   imm;
    logic                   use_imm;
    logic                   is_lui;
    logic                   reg_we;
    logic                   mem;
    logic                   mem_we;
  } decoded_t;

endpackage

`default_nettype wire

// File: rtl/ucore_cfg.svh
// Core-wide width settings for the ucore RTL
// Include this wherever a data, register or byte-enable width is needed

`ifndef UCORE_CFG_SVH
`define UCORE_CFG_SVH

// Data and address width
`define UCORE_XLEN 32

// Architectural register file
`define UCORE_NREGS 32
`define UCORE_REG_AW 5

// One enable per byte of a data word
`define UCORE_BE_W 4

`endif
